//--- common/esg_consts.svh
`ifndef ESG_CONSTS_SVH
`define ESG_CONSTS_SVH

// frame framing
`define ESG_SYNC 8'hA5

// settings RAM geometry
`define ESG_AW 8
`define ESG_DW 32

// range swept by the LED controller settings scan
`define ESG_SCAN_START 8'h00
`define ESG_SCAN_STOP  8'h0F

// settings words
`define ADDR_LED_PERIOD 8'h04 // blink period in ticks

// exec command addresses
`define ADDR_BLINK_ON 8'h10
`define ADDR_ALL_ON   8'h11
`define ADDR_ALL_OFF  8'h12
`define ADDR_0_ON     8'h13
`define ADDR_0_OFF    8'h14
`define ADDR_1_ON     8'h15
`define ADDR_1_OFF    8'h16

// 1 ms at 125 MHz
`define ESG_TICK_CYCLES_DEFAULT 125000

`endif

//--- common/esg_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// command frame types
////////////////////////////////////////////////////////////

package esg_pkg;

  // opcode byte, second byte of a frame
  // anything not listed here is reported as a command error
  typedef enum logic [7:0] {
    OP_WRITE = 8'h01, // addr + 4 data bytes, msb first
    OP_EXEC  = 8'h02  // addr only
  } esg_op_t;

  // parser position inside a frame
  typedef enum logic [1:0] {
    ST_SYNC = 2'd0, // hunting for sync byte
    ST_OP   = 2'd1, // next byte is the opcode
    ST_ADDR = 2'd2, // next byte is the address
    ST_DATA = 2'd3  // collecting write payload
  } esg_state_t;

endpackage : esg_pkg

`default_nettype wire

//--- common/led_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// LED controller types
////////////////////////////////////////////////////////////

package led_pkg;

  // static mode follows the per-LED on/off commands,
  // blink mode toggles both LEDs from the period setting
  typedef enum logic {
    MODE_STAT  = 1'b0,
    MODE_BLINK = 1'b1
  } led_mode_t;

endpackage : led_pkg

`default_nettype wire

//--- common/esg_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "esg_consts.svh"

////////////////////////////////////////////////////////////
// exec command channel
////////////////////////////////////////////////////////////

interface exe_if;

  logic                val;  // one cycle strobe
  logic [`ESG_AW-1:0]  addr; // command address, valid with val

  modport src (
    output val,
    output addr
  );

  modport dst (
    input val,
    input addr
  );

endinterface : exe_if

////////////////////////////////////////////////////////////
// settings RAM, one write port and one read port
////////////////////////////////////////////////////////////

interface prm_ram_if;

  logic                we; // write strobe
  logic [`ESG_AW-1:0]  wa;
  logic [`ESG_DW-1:0]  wd;
  logic [`ESG_AW-1:0]  ra;
  logic [`ESG_DW-1:0]  rq; // one clock after ra

  modport wr (
    output we,
    output wa,
    output wd
  );

  modport rd (
    output ra,
    input  rq
  );

  modport mem (
    input  we,
    input  wa,
    input  wd,
    input  ra,
    output rq
  );

endinterface : prm_ram_if

`default_nettype wire

//--- esg/esg_parser.sv
`timescale 1ns/1ps
`default_nettype none

`include "esg_consts.svh"

// byte stream in, RAM writes / exec strobes / error strobes out
// frame: sync, opcode, addr, [d3 d2 d1 d0 for writes]

module esg_parser
  import esg_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [7:0]  rxd,
  input  logic        rxv,
  exe_if.src          exe,
  prm_ram_if.wr       ram,
  output logic        cmd_err
);

  esg_state_t         state;
  esg_op_t            op;
  logic [1:0]         data_cnt; // payload bytes taken so far
  logic [`ESG_AW-1:0] addr;
  logic [`ESG_DW-1:0] data;

  ////////////////////////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_SYNC;
      data_cnt <= '0;
      ram.we   <= 1'b0;
      exe.val  <= 1'b0;
      cmd_err  <= 1'b0;
    end else begin
      // strobes last a single cycle
      ram.we  <= 1'b0;
      exe.val <= 1'b0;
      cmd_err <= 1'b0;
      if (rxv) begin
        case (state)
          ST_SYNC: begin
            if (rxd == `ESG_SYNC) state <= ST_OP; // garbage is dropped
          end
          ST_OP: begin
            case (rxd)
              OP_WRITE, OP_EXEC: state <= ST_ADDR;
              default: begin
                cmd_err <= 1'b1; // unknown opcode, resync
                state   <= ST_SYNC;
              end
            endcase
          end
          ST_ADDR: begin
            if (op == OP_EXEC) begin
              exe.val <= 1'b1; // frame ends here
              state   <= ST_SYNC;
            end else begin
              data_cnt <= '0;
              state    <= ST_DATA;
            end
          end
          ST_DATA: begin
            data_cnt <= data_cnt + 1'b1;
            if (data_cnt == 2'd3) begin
              ram.we <= 1'b1; // last payload byte
              state  <= ST_SYNC;
            end
          end
          default: state <= ST_SYNC;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // frame fields
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rxv) begin
      case (state)
        ST_OP:   op   <= esg_op_t'(rxd);
        ST_ADDR: addr <= rxd;
        ST_DATA: data <= {data[`ESG_DW-9:0], rxd}; // msb first
        default: ;
      endcase
    end
  end

  assign exe.addr = addr;
  assign ram.wa   = addr;
  assign ram.wd   = data; // complete word when we is high

endmodule : esg_parser

`default_nettype wire

//--- esg/esg_prm_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "esg_consts.svh"

// settings storage
// write side from the parser, read side swept by the LED controller

module esg_prm_ram (
  input  logic    clk,
  prm_ram_if.mem  ram
);

  localparam int DEPTH = 2 ** `ESG_AW;

  logic [`ESG_DW-1:0] mem [DEPTH];

  // power-up contents are zero, so an unwritten period reads as 0
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ram.we) mem[ram.wa] <= ram.wd;
  end

  ////////////////////////////////////////////////////////////
  // registered read port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    ram.rq <= mem[ram.ra]; // old data on same-address collision
  end

endmodule : esg_prm_ram

`default_nettype wire

//--- verilog/led_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "esg_consts.svh"

// two status LEDs, static on/off or blinking together

module led_control
  import led_pkg::*;
#(
  parameter int TICK_CYCLES = `ESG_TICK_CYCLES_DEFAULT
) (
  input  logic        clk,
  input  logic        rst,
  exe_if.dst          exe,
  prm_ram_if.rd       ram,
  output logic [1:0]  led
);

  localparam int TW = $clog2(TICK_CYCLES);
  localparam int PW = 16; // period width in ticks

  led_mode_t          cmd_mode; // from exec commands
  led_mode_t          mode;     // aligned with led
  logic [1:0]         led_raw;  // static values, bit per LED
  logic [`ESG_AW-1:0] ra_dl;
  logic [PW-1:0]      period;
  logic [TW-1:0]      tick_ctr;
  logic               tick;
  logic [PW-1:0]      ctr_blink;
  logic               blk;      // shared blink phase

  ////////////////////////////////////////////////////////////
  // settings scan
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ram.ra <= `ESG_SCAN_START;
      ra_dl  <= `ESG_SCAN_START;
      period <= '0;
    end else begin
      ram.ra <= (ram.ra == `ESG_SCAN_STOP) ? `ESG_SCAN_START : ram.ra + 1'b1;
      ra_dl  <= ram.ra; // lines up with rq
      if (ra_dl == `ADDR_LED_PERIOD) period <= ram.rq[PW-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // exec decode
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_mode <= MODE_BLINK;
      led_raw  <= 2'b00;
    end else if (exe.val) begin
      case (exe.addr)
        `ADDR_BLINK_ON: cmd_mode <= MODE_BLINK;
        `ADDR_ALL_ON: begin
          cmd_mode <= MODE_STAT;
          led_raw  <= 2'b11;
        end
        `ADDR_ALL_OFF: begin
          cmd_mode <= MODE_STAT;
          led_raw  <= 2'b00;
        end
        `ADDR_0_ON: begin
          cmd_mode   <= MODE_STAT;
          led_raw[0] <= 1'b1;
        end
        `ADDR_0_OFF: begin
          cmd_mode   <= MODE_STAT;
          led_raw[0] <= 1'b0;
        end
        `ADDR_1_ON: begin
          cmd_mode   <= MODE_STAT;
          led_raw[1] <= 1'b1;
        end
        `ADDR_1_OFF: begin
          cmd_mode   <= MODE_STAT;
          led_raw[1] <= 1'b0;
        end
        default: ; // not a LED command
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // millisecond tick
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      tick_ctr <= '0;
      tick     <= 1'b0;
    end else if (tick_ctr == TW'(TICK_CYCLES - 1)) begin
      tick_ctr <= '0;
      tick     <= 1'b1;
    end else begin
      tick_ctr <= tick_ctr + 1'b1;
      tick     <= 1'b0;
    end
  end

  // blink phase, toggles once every period+1 ticks
  always_ff @(posedge clk) begin
    if (rst) begin
      ctr_blink <= '0;
      blk       <= 1'b0;
    end else if (cmd_mode == MODE_BLINK && tick) begin
      ctr_blink <= (ctr_blink >= period) ? '0 : ctr_blink + 1'b1;
      if (ctr_blink == '0) blk <= ~blk;
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mode <= MODE_BLINK;
      led  <= 2'b00;
    end else begin
      mode <= cmd_mode;
      led  <= (cmd_mode == MODE_BLINK) ? {2{blk}} : led_raw;
    end
  end

endmodule : led_control

`default_nettype wire

//--- verilog/esg_led_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "esg_consts.svh"

// byte stream in, two LEDs out

module esg_led_top #(
  parameter int TICK_CYCLES = `ESG_TICK_CYCLES_DEFAULT
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [7:0]  rxd,     // transport rx byte
  input  logic        rxv,     // rx byte strobe
  output logic [1:0]  led,
  output logic        cmd_err  // unknown opcode
);

  exe_if     exe ();
  prm_ram_if ram ();

  ////////////////////////////////////////////////////////////
  // command side
  ////////////////////////////////////////////////////////////

  esg_parser parser_inst (
    .clk     (clk),
    .rst     (rst),
    .rxd     (rxd),
    .rxv     (rxv),
    .exe     (exe),
    .ram     (ram),
    .cmd_err (cmd_err)
  );

  esg_prm_ram ram_inst (
    .clk (clk),
    .ram (ram)
  );

  ////////////////////////////////////////////////////////////
  // LEDs
  ////////////////////////////////////////////////////////////

  led_control #(
    .TICK_CYCLES (TICK_CYCLES)
  ) led_inst (
    .clk (clk),
    .rst (rst),
    .exe (exe),
    .ram (ram),
    .led (led)
  );

endmodule : esg_led_top

`default_nettype wire

//--- tests/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

// free running clock, reset released a little after a rising edge

module tb_clkgen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst = 1'b0; // same offset as the stimulus
  end

endmodule : tb_clkgen

`default_nettype wire

//--- tests/esg_led_assert.sv
`timescale 1ns/1ps
`default_nettype none

// strobe and blink checks, bound into the parser and the LED controller

module esg_led_assert (
  input logic       clk,
  input logic       rst,
  input logic       val,   // exec strobe
  input logic       we,    // settings RAM write strobe
  input logic       blink, // controller in blink mode
  input logic [1:0] led
);

  // a frame ends as a write or as an exec, never both
  no_val_with_we : assert property (@(posedge clk) disable iff (rst) !(val && we))
    else $error("exec strobe and RAM write strobe high in the same cycle");

  val_one_cycle : assert property (@(posedge clk) disable iff (rst) val |=> !val)
    else $error("exec strobe held for more than one cycle");

  blink_leds_equal : assert property (@(posedge clk) disable iff (rst) blink |-> led[0] == led[1])
    else $error("LEDs differ while in blink mode");

endmodule : esg_led_assert

bind esg_parser esg_led_assert parser_chk (
  .clk   (clk),
  .rst   (rst),
  .val   (exe.val),
  .we    (ram.we),
  .blink (1'b0),
  .led   (2'b00)
);

bind led_control esg_led_assert led_chk (
  .clk   (clk),
  .rst   (rst),
  .val   (exe.val),
  .we    (1'b0),
  .blink (mode == MODE_BLINK),
  .led   (led)
);

`default_nettype wire

//--- tests/esg_led_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "esg_consts.svh"

module esg_led_tb;

  localparam int TICK_CYCLES = 10;
  localparam int MAX_REC     = 16;
  localparam int MAX_BYTES   = 12;
  localparam int MAX_GAP     = 3; // idle cycles between bytes
  localparam int SCAN_WAIT   = 2 + (`ESG_SCAN_STOP - `ESG_SCAN_START + 1);

  logic       clk;
  logic       rst;
  logic [7:0] rxd;
  logic       rxv;
  logic [1:0] led;
  logic       cmd_err;

  // records from the data file
  string      rec_name [MAX_REC];
  int         rec_len  [MAX_REC];
  logic [7:0] rec_byte [MAX_REC][MAX_BYTES];
  logic [1:0] rec_led  [MAX_REC];
  int         rec_err  [MAX_REC];
  int         rec_gap  [MAX_REC]; // blink gap in ticks, 0 for static checks
  int         n_rec;

  int err_count   = 0; // cmd_err pulses in the current test
  int cycle_count = 0;
  int cycle_limit = 0;
  int n_pass      = 0;
  int n_fail      = 0;
  bit test_ok;

  tb_clkgen #(
    .PERIOD_NS  (20),
    .RST_CYCLES (16)
  ) clk_gen (
    .clk (clk),
    .rst (rst)
  );

  esg_led_top #(
    .TICK_CYCLES (TICK_CYCLES)
  ) UUT (
    .clk     (clk),
    .rst     (rst),
    .rxd     (rxd),
    .rxv     (rxv),
    .led     (led),
    .cmd_err (cmd_err)
  );

  ////////////////////////////////////////////////////////////
  // monitors
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst && cmd_err) err_count++;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic load_records();
    int         fd;
    int         code;
    string      tok;
    string      rest;
    fd = $fopen("tests/esg_led_testdata.txt", "r");
    n_rec = 0;
    if (fd == 0) begin
      $display("cannot open tests/esg_led_testdata.txt");
    end else begin
      while (!$feof(fd) && n_rec < MAX_REC) begin
        code = $fscanf(fd, "%s", tok);
        if (code == 1) begin
          if (tok[0] == "#") begin
            code = $fgets(rest, fd); // comment line
          end else begin
            rec_name[n_rec] = tok;
            code = $fscanf(fd, "%d", rec_len[n_rec]);
            for (int i = 0; i < rec_len[n_rec]; i++) begin
              code = $fscanf(fd, "%h", rec_byte[n_rec][i]);
            end
            code = $fscanf(fd, "%h %d %d", rec_led[n_rec], rec_err[n_rec], rec_gap[n_rec]);
            n_rec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // worst case bytes with gaps plus the wait of the check
  function automatic int record_cycles(input int idx);
    int n;
    n = rec_len[idx] * (MAX_GAP + 1) + 4;
    if (rec_gap[idx] > 0) begin
      n += SCAN_WAIT + 5 + 4 * rec_gap[idx] * TICK_CYCLES + TICK_CYCLES;
    end
    return n;
  endfunction

  // entered and left 2 ns after a rising edge
  task automatic send_byte(input logic [7:0] b);
    int gap;
    gap = $urandom % (MAX_GAP + 1);
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
    rxd = b;
    rxv = 1'b1;
    @(posedge clk);
    #2;
    rxv = 1'b0;
    rxd = 8'h00;
  endtask

  task automatic check_static(input int idx);
    repeat (2) @(posedge clk); // third edge after the last byte
    @(negedge clk);
    assert (led == rec_led[idx]) else begin
      $display("** Error at %0t: led = %0h, expected %0h", $time, led, rec_led[idx]);
      test_ok = 1'b0;
    end
    assert (err_count == rec_err[idx]) else begin
      $display("** Error at %0t: cmd_err pulses = %0d, expected %0d",
               $time, err_count, rec_err[idx]);
      test_ok = 1'b0;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic check_blink(input int idx);
    int         want;
    int         window;
    int         cyc;
    int         toggles;
    int         t_first;
    int         t_second;
    logic [1:0] prev;
    bit         seen_hi;
    bit         seen_lo;
    want     = rec_gap[idx] * TICK_CYCLES;
    window   = 3 * want + TICK_CYCLES;
    cyc      = 0;
    toggles  = 0;
    t_first  = 0;
    t_second = 0;
    seen_hi  = 1'b0;
    seen_lo  = 1'b0;
    repeat (SCAN_WAIT + 3) @(posedge clk); // period and mode settle
    @(negedge clk);
    prev = led;
    while (toggles < 2 && cyc < window) begin
      @(negedge clk);
      cyc++;
      assert (led[1] == led[0]) else begin
        $display("** Error at %0t: led[1] = %b, expected %b", $time, led[1], led[0]);
        test_ok = 1'b0;
      end
      if (led[0]) begin
        seen_hi = 1'b1;
      end else begin
        seen_lo = 1'b1;
      end
      if (led != prev) begin
        toggles++;
        if (toggles == 1) t_first = cyc;
        else t_second = cyc;
      end
      prev = led;
    end
    assert (toggles == 2) else begin
      $display("LEDs toggled %0d times in %0d cycles, two toggles expected", toggles, window);
      test_ok = 1'b0;
    end
    assert (seen_hi && seen_lo) else begin
      $display("LEDs were not seen both on and off");
      test_ok = 1'b0;
    end
    if (toggles == 2) begin
      assert (t_second - t_first == want) else begin
        $display("** Error at %0t: led toggle gap = %0d, expected %0d",
                 $time, t_second - t_first, want);
        test_ok = 1'b0;
      end
    end
    assert (err_count == rec_err[idx]) else begin
      $display("** Error at %0t: cmd_err pulses = %0d, expected %0d",
               $time, err_count, rec_err[idx]);
      test_ok = 1'b0;
    end
    @(posedge clk);
    #2;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int total;
    rxd = 8'h00;
    rxv = 1'b0;
    void'($urandom(32'h9fa6_4dc8));
    load_records();
    total = 16;
    for (int r = 0; r < n_rec; r++) begin
      total += record_cycles(r);
    end
    cycle_limit = 2 * total;
    wait (rst === 1'b0);
    for (int r = 0; r < n_rec; r++) begin
      test_ok   = 1'b1;
      err_count = 0;
      for (int i = 0; i < rec_len[r]; i++) begin
        send_byte(rec_byte[r][i]);
      end
      if (rec_gap[r] > 0) check_blink(r);
      else check_static(r);
      if (test_ok) begin
        n_pass++;
        $display("%s: ok", rec_name[r]);
      end else begin
        n_fail++;
        $display("%s: FAILED", rec_name[r]);
      end
    end
    $display("tests run %0d, ok %0d, failing %0d", n_rec, n_pass, n_fail);
    if (n_fail == 0 && n_rec > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : esg_led_tb

`default_nettype wire

//--- verilog.f
+incdir+common
common/esg_pkg.sv
common/led_pkg.sv
common/esg_if.sv
esg/esg_parser.sv
esg/esg_prm_ram.sv
verilog/led_control.sv
verilog/esg_led_top.sv
tests/tb_clkgen.sv
tests/esg_led_assert.sv
tests/esg_led_tb.sv

//--- tests/esg_led_testdata.txt
# name nbytes byte... led err_pulses gap_ticks  (bytes and led in hex, the rest decimal)
# gap_ticks 0 checks led three cycles after the last byte, otherwise the blink toggle gap
after_reset    0 0 0 1
all_on         3 a5 02 11 3 0 0
led0_off       3 a5 02 14 2 0 0
led1_off       3 a5 02 16 0 0 0
led0_on        3 a5 02 13 1 0 0
bad_opcode     2 a5 07 1 1 0
sync_garbage   6 11 02 3c a5 02 15 3 0 0
bad_exec_addr  3 a5 02 20 3 0 0
blink_period   10 a5 01 04 00 00 00 04 a5 02 10 0 0 5
